// ==== rtl/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_ADDR_W = 8;

  // major opcodes handled by the back end
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef enum logic [4:0] {
    op_add, op_sub, op_sll, op_slt, op_sltu,
    op_xor, op_srl, op_sra, op_or, op_and,
    op_mul, op_mulh, op_mulhsu, op_mulhu,
    op_div, op_divu, op_rem, op_remu,
    op_lui,
    op_lb, op_lbu, op_lh, op_lhu, op_lw,
    op_sb, op_sh, op_sw
  } op_e;

  function automatic logic is_load(op_e op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
  endfunction

  function automatic logic is_store(op_e op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

  // everything except stores produces a register result
  function automatic logic writes_rd(op_e op);
    return !is_store(op);
  endfunction

endpackage

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  var logic clk,
  input  var logic reset,
  input  var logic instr_valid,
  input  var logic [31:0] instr,
  output var logic instr_ready,
  output var logic dec_valid,
  output var rv_exec_pkg::op_e dec_op,
  output var logic [rv_exec_pkg::REG_ADDR_W-1:0] dec_rd,
  output var logic [rv_exec_pkg::XLEN-1:0] dec_rs1_data,
  output var logic [rv_exec_pkg::XLEN-1:0] dec_rs2_data,
  output var logic [rv_exec_pkg::XLEN-1:0] dec_mem_addr,
  input  var logic exe_ready,
  input  var logic wb_valid,
  input  var logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd,
  input  var logic [rv_exec_pkg::XLEN-1:0] wb_data,
  input  var logic wb_release
);

  logic [rv_exec_pkg::XLEN-1:0] regs [32];
  logic [31:0] pending;
  logic [rv_exec_pkg::REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [9:0] funct;
  rv_exec_pkg::op_e op;
  logic legal;
  logic use_rs1, use_rs2, use_rd;
  logic hazard, accept;
  logic [rv_exec_pkg::XLEN-1:0] rs1_val, rs2_val, imm;

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd = instr[11:7];
  assign funct = {instr[31:25], instr[14:12]};

  always_comb begin
    op = rv_exec_pkg::op_add;
    legal = 1'b1;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (instr[6:0])
      rv_exec_pkg::OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct)
          10'b0000000_000: op = rv_exec_pkg::op_add;
          10'b0100000_000: op = rv_exec_pkg::op_sub;
          10'b0000000_001: op = rv_exec_pkg::op_sll;
          10'b0000000_010: op = rv_exec_pkg::op_slt;
          10'b0000000_011: op = rv_exec_pkg::op_sltu;
          10'b0000000_100: op = rv_exec_pkg::op_xor;
          10'b0000000_101: op = rv_exec_pkg::op_srl;
          10'b0100000_101: op = rv_exec_pkg::op_sra;
          10'b0000000_110: op = rv_exec_pkg::op_or;
          10'b0000000_111: op = rv_exec_pkg::op_and;
          10'b0000001_000: op = rv_exec_pkg::op_mul;
          10'b0000001_001: op = rv_exec_pkg::op_mulh;
          10'b0000001_010: op = rv_exec_pkg::op_mulhsu;
          10'b0000001_011: op = rv_exec_pkg::op_mulhu;
          10'b0000001_100: op = rv_exec_pkg::op_div;
          10'b0000001_101: op = rv_exec_pkg::op_divu;
          10'b0000001_110: op = rv_exec_pkg::op_rem;
          10'b0000001_111: op = rv_exec_pkg::op_remu;
          default: legal = 1'b0;
        endcase
      end
      rv_exec_pkg::OPC_LUI: op = rv_exec_pkg::op_lui;
      rv_exec_pkg::OPC_LOAD: begin
        use_rs1 = 1'b1;
        case (instr[14:12])
          3'b000: op = rv_exec_pkg::op_lb;
          3'b001: op = rv_exec_pkg::op_lh;
          3'b010: op = rv_exec_pkg::op_lw;
          3'b100: op = rv_exec_pkg::op_lbu;
          3'b101: op = rv_exec_pkg::op_lhu;
          default: legal = 1'b0;
        endcase
      end
      rv_exec_pkg::OPC_STORE: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (instr[14:12])
          3'b000: op = rv_exec_pkg::op_sb;
          3'b001: op = rv_exec_pkg::op_sh;
          3'b010: op = rv_exec_pkg::op_sw;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  assign use_rd = legal && rv_exec_pkg::writes_rd(op);

  // hold back anything touching a register still in flight
  assign hazard = legal && ((use_rs1 && pending[rs1]) || (use_rs2 && pending[rs2]) ||
                            (use_rd && pending[rd]));
  assign instr_ready = !(dec_valid && !exe_ready) && !hazard;
  assign accept = instr_valid && instr_ready;

  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
  assign imm = rv_exec_pkg::is_store(op) ? {{20{instr[31]}}, instr[31:25], instr[11:7]}
                                         : {{20{instr[31]}}, instr[31:20]};

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
      pending <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb_valid) regs[wb_rd] <= wb_data;
      if (dec_valid && exe_ready) dec_valid <= 1'b0;
      if (accept && legal) dec_valid <= 1'b1;
      if (wb_release) pending[wb_rd] <= 1'b0;
      if (accept && use_rd) pending[rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && legal) begin
      dec_op <= op;
      dec_rd <= rd;
      dec_rs1_data <= (op == rv_exec_pkg::op_lui) ? {instr[31:12], 12'b0} : rs1_val;
      dec_rs2_data <= rs2_val;
      dec_mem_addr <= rs1_val + imm;
    end
  end

  // operands are never read while their writeback is still outstanding
  assert property (@(posedge clk) disable iff (reset)
    accept && legal |->
      !(use_rs1 && (pending[rs1] || (wb_valid && wb_rd == rs1))) &&
      !(use_rs2 && (pending[rs2] || (wb_valid && wb_rd == rs2))));

endmodule

`default_nettype wire

// ==== rtl/executor.sv ====
`timescale 1ns/10ps
`default_nettype none

module executor (
  input  var logic clk,
  input  var logic reset,
  input  var logic dec_valid,
  output var logic exe_ready,
  input  var rv_exec_pkg::op_e dec_op,
  input  var logic [rv_exec_pkg::REG_ADDR_W-1:0] dec_rd,
  input  var logic [rv_exec_pkg::XLEN-1:0] dec_rs1_data,
  input  var logic [rv_exec_pkg::XLEN-1:0] dec_rs2_data,
  input  var logic [rv_exec_pkg::XLEN-1:0] dec_mem_addr,
  output var logic exe_valid,
  input  var logic acc_ready,
  output var rv_exec_pkg::op_e exe_op,
  output var logic [rv_exec_pkg::REG_ADDR_W-1:0] exe_rd,
  output var logic [rv_exec_pkg::XLEN-1:0] exe_result,
  output var logic [rv_exec_pkg::XLEN-1:0] exe_mem_addr
);

  typedef enum logic [1:0] {st_idle, st_mul, st_div, st_hold} state_e;

  state_e state;
  logic [6:0] count;
  logic [63:0] mul_div_x, mul_div_y, mul_div_store;
  logic [63:0] rem_shift;
  logic [31:0] op_a, op_b;
  logic [31:0] abs_a, abs_b;
  logic [31:0] quot, rem;
  logic [31:0] alu_result, div_result;
  logic [4:0] shamt;
  logic mul_sel, div_sel;
  logic div_signed, neg_quot, neg_rem;

  assign exe_ready = (state == st_idle);
  assign exe_valid = (state == st_hold);

  assign mul_sel = dec_op inside {rv_exec_pkg::op_mul, rv_exec_pkg::op_mulh,
                                  rv_exec_pkg::op_mulhsu, rv_exec_pkg::op_mulhu};
  assign div_sel = dec_op inside {rv_exec_pkg::op_div, rv_exec_pkg::op_divu,
                                  rv_exec_pkg::op_rem, rv_exec_pkg::op_remu};
  assign shamt = dec_rs2_data[4:0];

  // single step results, stores pass their data through
  always_comb begin
    case (dec_op)
      rv_exec_pkg::op_add: alu_result = dec_rs1_data + dec_rs2_data;
      rv_exec_pkg::op_sub: alu_result = dec_rs1_data - dec_rs2_data;
      rv_exec_pkg::op_sll: alu_result = dec_rs1_data << shamt;
      rv_exec_pkg::op_slt: alu_result = {31'b0, $signed(dec_rs1_data) < $signed(dec_rs2_data)};
      rv_exec_pkg::op_sltu: alu_result = {31'b0, dec_rs1_data < dec_rs2_data};
      rv_exec_pkg::op_xor: alu_result = dec_rs1_data ^ dec_rs2_data;
      rv_exec_pkg::op_srl: alu_result = dec_rs1_data >> shamt;
      rv_exec_pkg::op_sra: alu_result = $signed(dec_rs1_data) >>> shamt;
      rv_exec_pkg::op_or: alu_result = dec_rs1_data | dec_rs2_data;
      rv_exec_pkg::op_and: alu_result = dec_rs1_data & dec_rs2_data;
      rv_exec_pkg::op_lui: alu_result = dec_rs1_data;
      default: alu_result = dec_rs2_data;
    endcase
  end

  // divider works on magnitudes, signs fixed up at the end
  assign div_signed = exe_op inside {rv_exec_pkg::op_div, rv_exec_pkg::op_rem};
  assign abs_a = (div_signed && op_a[31]) ? -op_a : op_a;
  assign abs_b = (div_signed && op_b[31]) ? -op_b : op_b;
  assign neg_quot = div_signed && (op_a[31] != op_b[31]) && (op_b != '0);
  assign neg_rem = div_signed && op_a[31];
  assign rem_shift = {mul_div_x[62:0], mul_div_store[63]};
  assign quot = mul_div_store[31:0];
  assign rem = mul_div_x[31:0];
  assign div_result = (exe_op inside {rv_exec_pkg::op_div, rv_exec_pkg::op_divu})
                      ? (neg_quot ? -quot : quot) : (neg_rem ? -rem : rem);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (dec_valid) begin
            if (mul_sel) begin
              state <= st_mul;
              count <= (dec_op == rv_exec_pkg::op_mul) ? 7'd32 : 7'd64;
            end else if (div_sel) begin
              // one extra step to load the magnitudes
              state <= st_div;
              count <= 7'd65;
            end else begin
              state <= st_hold;
            end
          end
        end
        st_mul, st_div: begin
          if (count == '0) state <= st_hold;
          else count <= count - 7'd1;
        end
        st_hold: if (acc_ready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (dec_valid) begin
          exe_op <= dec_op;
          exe_rd <= dec_rd;
          exe_mem_addr <= dec_mem_addr;
          exe_result <= alu_result;
          op_a <= dec_rs1_data;
          op_b <= dec_rs2_data;
          mul_div_store <= '0;
          mul_div_x <= (dec_op inside {rv_exec_pkg::op_mulh, rv_exec_pkg::op_mulhsu})
                       ? {{32{dec_rs1_data[31]}}, dec_rs1_data} : {32'b0, dec_rs1_data};
          mul_div_y <= (dec_op == rv_exec_pkg::op_mulh)
                       ? {{32{dec_rs2_data[31]}}, dec_rs2_data} : {32'b0, dec_rs2_data};
        end
      end
      st_mul: begin
        if (count != '0) begin
          if (mul_div_y[0]) mul_div_store <= mul_div_store + mul_div_x;
          mul_div_x <= mul_div_x << 1;
          mul_div_y <= mul_div_y >> 1;
        end else if (exe_op == rv_exec_pkg::op_mul) begin
          exe_result <= mul_div_store[31:0];
        end else begin
          exe_result <= mul_div_store[63:32];
        end
      end
      st_div: begin
        if (count == 7'd65) begin
          // quotient bits shift in behind the dividend
          mul_div_x <= '0;
          mul_div_y <= {32'b0, abs_b};
          mul_div_store <= {32'b0, abs_a};
        end else if (count != '0) begin
          if (rem_shift >= mul_div_y) begin
            mul_div_x <= rem_shift - mul_div_y;
            mul_div_store <= {mul_div_store[62:0], 1'b1};
          end else begin
            mul_div_x <= rem_shift;
            mul_div_store <= {mul_div_store[62:0], 1'b0};
          end
        end else begin
          exe_result <= div_result;
        end
      end
      default: ;
    endcase
  end

  // held result survives back-pressure from the accessor
  assert property (@(posedge clk) disable iff (reset)
    exe_valid && !acc_ready |=> exe_valid && $stable(exe_result));

endmodule

`default_nettype wire

// ==== rtl/mem_accessor.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_accessor (
  input  var logic clk,
  input  var logic reset,
  input  var logic exe_valid,
  output var logic acc_ready,
  input  var rv_exec_pkg::op_e exe_op,
  input  var logic [rv_exec_pkg::REG_ADDR_W-1:0] exe_rd,
  input  var logic [rv_exec_pkg::XLEN-1:0] exe_result,
  input  var logic [rv_exec_pkg::XLEN-1:0] exe_mem_addr,
  output var logic wb_valid,
  output var logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd,
  output var logic [rv_exec_pkg::XLEN-1:0] wb_data,
  output var logic wb_release
);

  logic [rv_exec_pkg::XLEN-1:0] dmem [rv_exec_pkg::DMEM_WORDS];
  logic [rv_exec_pkg::DMEM_ADDR_W-1:0] widx;
  logic [1:0] boff;
  logic accept, load, store;
  logic load_busy;
  rv_exec_pkg::op_e ld_op;
  logic [1:0] ld_off;
  logic [rv_exec_pkg::REG_ADDR_W-1:0] ld_rd;
  logic [rv_exec_pkg::XLEN-1:0] rdata, load_data;
  logic [7:0] ld_byte;
  logic [15:0] ld_half;

  assign acc_ready = !load_busy;
  assign accept = exe_valid && acc_ready;
  assign load = rv_exec_pkg::is_load(exe_op);
  assign store = rv_exec_pkg::is_store(exe_op);
  // word index wraps above bit 9
  assign widx = exe_mem_addr[rv_exec_pkg::DMEM_ADDR_W+1:2];
  assign boff = exe_mem_addr[1:0];

  assign ld_byte = rdata[8*ld_off +: 8];
  assign ld_half = ld_off[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (ld_op)
      rv_exec_pkg::op_lb: load_data = {{24{ld_byte[7]}}, ld_byte};
      rv_exec_pkg::op_lbu: load_data = {24'b0, ld_byte};
      rv_exec_pkg::op_lh: load_data = {{16{ld_half[15]}}, ld_half};
      rv_exec_pkg::op_lhu: load_data = {16'b0, ld_half};
      default: load_data = rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rv_exec_pkg::DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (accept && store) begin
      case (exe_op)
        rv_exec_pkg::op_sb: dmem[widx][8*boff +: 8] <= exe_result[7:0];
        rv_exec_pkg::op_sh: begin
          if (boff[1]) dmem[widx][31:16] <= exe_result[15:0];
          else dmem[widx][15:0] <= exe_result[15:0];
        end
        default: dmem[widx] <= exe_result;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load_busy <= 1'b0;
      wb_valid <= 1'b0;
      wb_release <= 1'b0;
    end else begin
      wb_valid <= 1'b0;
      wb_release <= 1'b0;
      if (load_busy) begin
        load_busy <= 1'b0;
        wb_valid <= (ld_rd != '0);
        wb_release <= 1'b1;
      end else if (accept && load) begin
        load_busy <= 1'b1;
      end else if (accept && !store) begin
        wb_valid <= (exe_rd != '0);
        wb_release <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && load) begin
      rdata <= dmem[widx];
      ld_op <= exe_op;
      ld_off <= boff;
      ld_rd <= exe_rd;
    end
    if (load_busy) begin
      wb_rd <= ld_rd;
      wb_data <= load_data;
    end else if (accept && !store) begin
      wb_rd <= exe_rd;
      wb_data <= exe_result;
    end
  end

  // every register write also frees its pending bit
  assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> wb_release && wb_rd != '0);

endmodule

`default_nettype wire

// ==== rtl/exec_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_top (
  input  var logic clk,
  input  var logic reset,
  input  var logic instr_valid,
  input  var logic [31:0] instr,
  output var logic instr_ready,
  output var logic wb_valid,
  output var logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd,
  output var logic [rv_exec_pkg::XLEN-1:0] wb_data
);

  logic dec_valid, exe_ready;
  rv_exec_pkg::op_e dec_op;
  logic [rv_exec_pkg::REG_ADDR_W-1:0] dec_rd;
  logic [rv_exec_pkg::XLEN-1:0] dec_rs1_data, dec_rs2_data, dec_mem_addr;
  logic exe_valid, acc_ready;
  rv_exec_pkg::op_e exe_op;
  logic [rv_exec_pkg::REG_ADDR_W-1:0] exe_rd;
  logic [rv_exec_pkg::XLEN-1:0] exe_result, exe_mem_addr;
  logic wb_release;

  instr_decoder instr_decoder_i (
    .clk(clk),
    .reset(reset),
    .instr_valid(instr_valid),
    .instr(instr),
    .instr_ready(instr_ready),
    .dec_valid(dec_valid),
    .dec_op(dec_op),
    .dec_rd(dec_rd),
    .dec_rs1_data(dec_rs1_data),
    .dec_rs2_data(dec_rs2_data),
    .dec_mem_addr(dec_mem_addr),
    .exe_ready(exe_ready),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data),
    .wb_release(wb_release)
  );

  executor executor_i (
    .clk(clk),
    .reset(reset),
    .dec_valid(dec_valid),
    .exe_ready(exe_ready),
    .dec_op(dec_op),
    .dec_rd(dec_rd),
    .dec_rs1_data(dec_rs1_data),
    .dec_rs2_data(dec_rs2_data),
    .dec_mem_addr(dec_mem_addr),
    .exe_valid(exe_valid),
    .acc_ready(acc_ready),
    .exe_op(exe_op),
    .exe_rd(exe_rd),
    .exe_result(exe_result),
    .exe_mem_addr(exe_mem_addr)
  );

  mem_accessor mem_accessor_i (
    .clk(clk),
    .reset(reset),
    .exe_valid(exe_valid),
    .acc_ready(acc_ready),
    .exe_op(exe_op),
    .exe_rd(exe_rd),
    .exe_result(exe_result),
    .exe_mem_addr(exe_mem_addr),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data),
    .wb_release(wb_release)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_exec_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exec_top;

  logic clk;
  logic reset;
  logic instr_valid;
  logic [31:0] instr;
  logic instr_ready;
  logic wb_valid;
  logic [rv_exec_pkg::REG_ADDR_W-1:0] wb_rd;
  logic [rv_exec_pkg::XLEN-1:0] wb_data;

  logic [31:0] prog [$];
  logic [rv_exec_pkg::REG_ADDR_W-1:0] exp_rd_q [$];
  logic [rv_exec_pkg::XLEN-1:0] exp_data_q [$];
  logic [31:0] model_regs [32];
  logic [31:0] model_mem [rv_exec_pkg::DMEM_WORDS];
  int cycle_count = 0;
  int cycle_limit = 0;
  int wb_count = 0;
  int drain_cycles = 0;

  exec_top exec_top_i (
    .clk(clk),
    .reset(reset),
    .instr_valid(instr_valid),
    .instr(instr),
    .instr_ready(instr_ready),
    .wb_valid(wb_valid),
    .wb_rd(wb_rd),
    .wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_rd(input logic [rv_exec_pkg::REG_ADDR_W-1:0] got,
                          input logic [rv_exec_pkg::REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch wb_rd: got 0x%h, expected 0x%h (writeback %0d)",
                         got, exp, wb_count));
    end
  endtask

  task automatic check_data(input logic [rv_exec_pkg::XLEN-1:0] got,
                            input logic [rv_exec_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch wb_data: got 0x%h, expected 0x%h (writeback %0d)",
                         got, exp, wb_count));
    end
  endtask

  // expected register result per RV32IM
  function automatic logic [31:0] exec_ref(input rv_exec_pkg::op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
    logic signed [31:0] sa, sb;
    logic [63:0] ss, su, uu;
    logic [4:0] sh;
    logic div_zero, overflow;
    sa = a;
    sb = b;
    sh = b[4:0];
    ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    su = {{32{a[31]}}, a} * {32'h0, b};
    uu = {32'h0, a} * {32'h0, b};
    div_zero = (b == 32'h0);
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      rv_exec_pkg::op_add: return a + b;
      rv_exec_pkg::op_sub: return a - b;
      rv_exec_pkg::op_sll: return a << sh;
      rv_exec_pkg::op_slt: return (sa < sb) ? 32'h1 : 32'h0;
      rv_exec_pkg::op_sltu: return (a < b) ? 32'h1 : 32'h0;
      rv_exec_pkg::op_xor: return a ^ b;
      rv_exec_pkg::op_srl: return a >> sh;
      rv_exec_pkg::op_sra: return sa >>> sh;
      rv_exec_pkg::op_or: return a | b;
      rv_exec_pkg::op_and: return a & b;
      rv_exec_pkg::op_mul: return uu[31:0];
      rv_exec_pkg::op_mulh: return ss[63:32];
      rv_exec_pkg::op_mulhsu: return su[63:32];
      rv_exec_pkg::op_mulhu: return uu[63:32];
      rv_exec_pkg::op_div: begin
        if (div_zero) return 32'hffff_ffff;
        if (overflow) return a;
        return sa / sb;
      end
      rv_exec_pkg::op_rem: begin
        if (div_zero) return a;
        if (overflow) return 32'h0;
        return sa % sb;
      end
      rv_exec_pkg::op_divu: return div_zero ? 32'hffff_ffff : a / b;
      rv_exec_pkg::op_remu: return div_zero ? a : a % b;
      rv_exec_pkg::op_lui: return a;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input rv_exec_pkg::op_e op, input logic [31:0] word,
                                           input logic [1:0] off);
    logic [31:0] byte_lane, half_lane;
    byte_lane = word >> {off, 3'b000};
    half_lane = word >> {off[1], 4'b0000};
    case (op)
      rv_exec_pkg::op_lb: return {{24{byte_lane[7]}}, byte_lane[7:0]};
      rv_exec_pkg::op_lbu: return {24'h0, byte_lane[7:0]};
      rv_exec_pkg::op_lh: return {{16{half_lane[15]}}, half_lane[15:0]};
      rv_exec_pkg::op_lhu: return {16'h0, half_lane[15:0]};
      default: return word;
    endcase
  endfunction

  function automatic logic [9:0] r_funct(input rv_exec_pkg::op_e op);
    case (op)
      rv_exec_pkg::op_sub: return {7'h20, 3'd0};
      rv_exec_pkg::op_sll: return {7'h00, 3'd1};
      rv_exec_pkg::op_slt: return {7'h00, 3'd2};
      rv_exec_pkg::op_sltu: return {7'h00, 3'd3};
      rv_exec_pkg::op_xor: return {7'h00, 3'd4};
      rv_exec_pkg::op_srl: return {7'h00, 3'd5};
      rv_exec_pkg::op_sra: return {7'h20, 3'd5};
      rv_exec_pkg::op_or: return {7'h00, 3'd6};
      rv_exec_pkg::op_and: return {7'h00, 3'd7};
      rv_exec_pkg::op_mul: return {7'h01, 3'd0};
      rv_exec_pkg::op_mulh: return {7'h01, 3'd1};
      rv_exec_pkg::op_mulhsu: return {7'h01, 3'd2};
      rv_exec_pkg::op_mulhu: return {7'h01, 3'd3};
      rv_exec_pkg::op_div: return {7'h01, 3'd4};
      rv_exec_pkg::op_divu: return {7'h01, 3'd5};
      rv_exec_pkg::op_rem: return {7'h01, 3'd6};
      rv_exec_pkg::op_remu: return {7'h01, 3'd7};
      default: return {7'h00, 3'd0};
    endcase
  endfunction

  function automatic logic [2:0] mem_funct3(input rv_exec_pkg::op_e op);
    case (op)
      rv_exec_pkg::op_lh, rv_exec_pkg::op_sh: return 3'd1;
      rv_exec_pkg::op_lw, rv_exec_pkg::op_sw: return 3'd2;
      rv_exec_pkg::op_lbu: return 3'd4;
      rv_exec_pkg::op_lhu: return 3'd5;
      default: return 3'd0;
    endcase
  endfunction

  // offset in -8..7 so loads land on recently stored bytes
  function automatic logic [11:0] near_offset();
    logic [31:0] r;
    r = $urandom;
    return {8'h00, r[3:0]} - 12'd8;
  endfunction

  task automatic retire_expect(input logic [4:0] rd, input logic [31:0] value);
    if (rd != 5'd0) begin
      model_regs[rd] = value;
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(value);
    end
  endtask

  task automatic lui_to(input logic [4:0] rd, input logic [19:0] imm);
    prog.push_back({imm, rd, 7'b0110111});
    retire_expect(rd, exec_ref(rv_exec_pkg::op_lui, {imm, 12'h000}, 32'h0));
  endtask

  task automatic rtype_op(input rv_exec_pkg::op_e op, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
    logic [9:0] f;
    f = r_funct(op);
    prog.push_back({f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011});
    retire_expect(rd, exec_ref(op, model_regs[rs1], model_regs[rs2]));
  endtask

  task automatic load_from(input rv_exec_pkg::op_e op, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr;
    addr = model_regs[rs1] + {{20{imm[11]}}, imm};
    prog.push_back({imm, rs1, mem_funct3(op), rd, 7'b0000011});
    retire_expect(rd, load_ref(op, model_mem[addr[9:2]], addr[1:0]));
  endtask

  task automatic store_to(input rv_exec_pkg::op_e op, input logic [4:0] rs2,
                          input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] addr, mask;
    logic [4:0] lane_shift;
    addr = model_regs[rs1] + {{20{imm[11]}}, imm};
    case (op)
      rv_exec_pkg::op_sb: lane_shift = {addr[1:0], 3'b000};
      rv_exec_pkg::op_sh: lane_shift = {addr[1], 4'b0000};
      default: lane_shift = 5'd0;
    endcase
    case (op)
      rv_exec_pkg::op_sb: mask = 32'h0000_00ff << lane_shift;
      rv_exec_pkg::op_sh: mask = 32'h0000_ffff << lane_shift;
      default: mask = 32'hffff_ffff;
    endcase
    model_mem[addr[9:2]] = (model_mem[addr[9:2]] & ~mask) |
                           ((model_regs[rs2] << lane_shift) & mask);
    prog.push_back({imm[11:5], rs2, rs1, mem_funct3(op), imm[4:0], 7'b0100011});
  endtask

  // full word via lui, a shifted lui in x30 and xor, x31 holds 12
  task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
    lui_to(rd, value[31:12]);
    lui_to(5'd30, {8'h00, value[11:0]});
    rtype_op(rv_exec_pkg::op_srl, 5'd30, 5'd30, 5'd31);
    rtype_op(rv_exec_pkg::op_xor, rd, rd, 5'd30);
  endtask

  task automatic insert_illegal();
    logic [31:0] r;
    r = $urandom;
    case (r[1:0])
      2'd0: prog.push_back({r[31:7], 7'b0010011});
      2'd1: prog.push_back({7'b0000010, r[24:7], 7'b0110011});
      2'd2: prog.push_back({r[31:15], 2'b11, r[12:7], 7'b0000011});
      default: prog.push_back({r[31:15], 1'b1, r[13:7], 7'b0100011});
    endcase
  endtask

  task automatic build_program();
    logic [31:0] r;
    rv_exec_pkg::op_e alu_ops [10];
    rv_exec_pkg::op_e md_ops [8];
    rv_exec_pkg::op_e ld_ops [5];
    logic [31:0] pair_a [11];
    logic [31:0] pair_b [11];
    alu_ops = '{rv_exec_pkg::op_add, rv_exec_pkg::op_sub, rv_exec_pkg::op_sll,
                rv_exec_pkg::op_slt, rv_exec_pkg::op_sltu, rv_exec_pkg::op_xor,
                rv_exec_pkg::op_srl, rv_exec_pkg::op_sra, rv_exec_pkg::op_or,
                rv_exec_pkg::op_and};
    md_ops = '{rv_exec_pkg::op_mul, rv_exec_pkg::op_mulh, rv_exec_pkg::op_mulhsu,
               rv_exec_pkg::op_mulhu, rv_exec_pkg::op_div, rv_exec_pkg::op_divu,
               rv_exec_pkg::op_rem, rv_exec_pkg::op_remu};
    ld_ops = '{rv_exec_pkg::op_lb, rv_exec_pkg::op_lbu, rv_exec_pkg::op_lh,
               rv_exec_pkg::op_lhu, rv_exec_pkg::op_lw};
    pair_a = '{32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0001,
               32'h0, 32'hffff_fff9, 32'h0, 32'h0, 32'h0, 32'h0};
    pair_b = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
               32'h0, 32'h0000_0002, 32'h0, 32'h0, 32'h0, 32'h0};
    pair_a[5] = $urandom;
    for (int i = 7; i < 11; i++) begin
      pair_a[i] = $urandom;
      pair_b[i] = $urandom;
    end

    // x31 = 12 built from sltu and adds
    lui_to(5'd30, 20'h80000);
    rtype_op(rv_exec_pkg::op_sltu, 5'd31, 5'd0, 5'd30);
    rtype_op(rv_exec_pkg::op_add, 5'd31, 5'd31, 5'd31);
    rtype_op(rv_exec_pkg::op_add, 5'd31, 5'd31, 5'd31);
    rtype_op(rv_exec_pkg::op_add, 5'd30, 5'd31, 5'd31);
    rtype_op(rv_exec_pkg::op_add, 5'd31, 5'd31, 5'd30);

    for (int i = 0; i < 6; i++) begin
      r = $urandom;
      lui_to(5'd13, r[19:0]);
      set_reg(5'd1, $urandom);
      set_reg(5'd2, $urandom);
      foreach (alu_ops[k]) rtype_op(alu_ops[k], 5'(k + 3), 5'd1, 5'd2);
      insert_illegal();
    end

    // multiply and divide corners, then random pairs
    foreach (pair_a[i]) begin
      set_reg(5'd1, pair_a[i]);
      set_reg(5'd2, pair_b[i]);
      foreach (md_ops[k]) rtype_op(md_ops[k], 5'(k + 3), 5'd1, 5'd2);
    end

    for (int i = 0; i < 6; i++) begin
      set_reg(5'd10, $urandom);
      set_reg(5'd11, $urandom);
      store_to(rv_exec_pkg::op_sw, 5'd11, 5'd10, near_offset());
      store_to(rv_exec_pkg::op_sh, 5'd3, 5'd10, near_offset());
      store_to(rv_exec_pkg::op_sb, 5'd4, 5'd10, near_offset());
      foreach (ld_ops[k]) begin
        load_from(ld_ops[k], 5'(k + 12), 5'd10, near_offset());
        load_from(ld_ops[k], 5'(k + 17), 5'd10, near_offset());
      end
    end

    // byte address 0x400 wraps onto word 0
    set_reg(5'd12, 32'h0000_03fc);
    store_to(rv_exec_pkg::op_sw, 5'd11, 5'd12, 12'h004);
    load_from(rv_exec_pkg::op_lw, 5'd13, 5'd0, 12'h000);
    load_from(rv_exec_pkg::op_lh, 5'd14, 5'd12, 12'h006);

    // dependent chain, load result used as address
    set_reg(5'd12, 32'h0000_0100);
    set_reg(5'd11, 32'h0000_0040);
    store_to(rv_exec_pkg::op_sw, 5'd11, 5'd12, 12'h000);
    load_from(rv_exec_pkg::op_lw, 5'd13, 5'd12, 12'h000);
    load_from(rv_exec_pkg::op_lw, 5'd14, 5'd13, 12'h0c0);
    rtype_op(rv_exec_pkg::op_add, 5'd15, 5'd14, 5'd13);
    rtype_op(rv_exec_pkg::op_mul, 5'd16, 5'd15, 5'd15);
    rtype_op(rv_exec_pkg::op_div, 5'd17, 5'd16, 5'd14);
    rtype_op(rv_exec_pkg::op_add, 5'd0, 5'd17, 5'd17);
    load_from(rv_exec_pkg::op_lw, 5'd0, 5'd12, 12'h000);
    lui_to(5'd0, 20'hfffff);
    rtype_op(rv_exec_pkg::op_sub, 5'd18, 5'd0, 5'd17);

    // random mix with illegal words, rd may be x0
    for (int i = 0; i < 40; i++) begin
      r = $urandom;
      if (r[3:0] < 4'd5) begin
        insert_illegal();
      end else if (r[8:5] < 4'd10) begin
        rtype_op(alu_ops[r[8:5]], {2'b00, r[11:9]}, {2'b00, r[14:12]}, {2'b00, r[17:15]});
      end else begin
        rtype_op(md_ops[r[7:5]], {2'b00, r[11:9]}, {2'b00, r[14:12]}, {2'b00, r[17:15]});
      end
    end
  endtask

  task automatic send_instr(input logic [31:0] word);
    logic taken;
    instr = word;
    instr_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = instr_ready;
      @(posedge clk);
    end
    #1;
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      fail_run($sformatf("timed out after %0d cycles with %0d writebacks still expected",
                         cycle_count, exp_rd_q.size()));
    end
  end

  // writebacks are one-cycle pulses, stable at the falling edge
  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      if (exp_rd_q.size() == 0) begin
        fail_run($sformatf("writeback to x%0d arrived when no result was expected", wb_rd));
      end else begin
        check_rd(wb_rd, exp_rd_q.pop_front());
        check_data(wb_data, exp_data_q.pop_front());
        wb_count = wb_count + 1;
      end
    end
  end

  initial begin
    instr_valid = 1'b0;
    instr = 32'h0;
    reset = 1'b1;
    void'($urandom(70));
    foreach (model_regs[i]) model_regs[i] = 32'h0;
    foreach (model_mem[i]) model_mem[i] = 32'h0;
    build_program();
    cycle_limit = 70 * prog.size() + 200;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (prog[i]) send_instr(prog[i]);
    instr_valid = 1'b0;
    // at most three instructions still in flight
    while (exp_rd_q.size() != 0 && drain_cycles < 3 * 70) begin
      @(posedge clk);
      drain_cycles = drain_cycles + 1;
    end
    // spare cycles so a stray writeback still gets caught
    repeat (20) @(posedge clk);
    if (exp_rd_q.size() != 0) begin
      fail_run($sformatf("%0d expected writebacks never arrived", exp_rd_q.size()));
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/rv_exec_pkg.sv
rtl/instr_decoder.sv
rtl/executor.sv
rtl/mem_accessor.sv
rtl/exec_top.sv
testbench/tb_exec_top.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f src.f --top-module tb_exec_top \
  -Mdir obj_dir -o sim_exec_top > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_exec_top > sim.log 2>&1
cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
